// ==== msg_loop_test.f ====
hdl/msg_pkg.sv
hdl/redun_calc.sv
hdl/msg_source.sv
hdl/msg_router.sv
hdl/msg_sink.sv
hdl/loop_ctrl.sv
hdl/msg_loop_test.sv
tb/tb_msg_loop_test.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= tb_msg_loop_test
FILELIST ?= msg_loop_test.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -j 0

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tb/tb_msg_loop_test.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_msg_loop_test;

	localparam int n_fixed = 6;
	localparam int n_rand = 4;
	localparam int n_rows = n_fixed + n_rand;

	logic snk0_clk;
	logic rst_n;
	logic start;
	logic [7:0] msg_limit;
	logic inject_fault;
	logic done;
	logic err0;
	logic err1;
	logic [7:0] count0;
	logic [7:0] count1;
	logic [3:0] disp0;
	logic [3:0] disp1;

	// Stimulus columns
	int t_limit [n_rows];
	int t_fault_en [n_rows];
	int t_fault_at [n_rows];

	// Expected columns, filled by the model
	int e_count0 [n_rows];
	int e_count1 [n_rows];
	int e_err0 [n_rows];
	int e_err1 [n_rows];
	int e_disp0 [n_rows];
	int e_disp1 [n_rows];

	// Model state, carried across runs like the source and sinks
	int m_dst;
	int m_cnt [2];
	int m_disp [2];

	logic [31:0] lfsr;
	int cycles;
	int max_cycles;

	msg_loop_test u_msg_loop_test (
		.snk0_clk(snk0_clk),
		.rst_n(rst_n),
		.start(start),
		.msg_limit(msg_limit),
		.inject_fault(inject_fault),
		.done(done),
		.err0(err0),
		.err1(err1),
		.count0(count0),
		.count1(count1),
		.disp0(disp0),
		.disp1(disp1)
	);

	initial begin
		snk0_clk = 1'b0;
		forever #10 snk0_clk = ~snk0_clk;
	end

	always @(posedge snk0_clk) begin
		cycles <= cycles + 1;
		if (cycles >= max_cycles) begin
			$display("run timed out after %0d cycles waiting for done", cycles);
			$display("SOME TESTS FAILED");
			$fatal(1);
		end
	end

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		logic fb;
		fb = s[31] ^ s[21] ^ s[1] ^ s[0];
		return {s[30:0], fb};
	endfunction

	task automatic take_byte(output int val);
		int k;
		val = 0;
		for (k = 0; k < 8; k++) begin
			lfsr = lfsr_next(lfsr);
			val = (val << 1) | int'(lfsr[0]);
		end
	endtask

	task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("error %s: got 0x%h, expected 0x%h", name, got, exp);
			$display("SOME TESTS FAILED");
			$fatal(1);
		end
	endtask

	task automatic set_row(input int idx, input int lim, input int fault_en, input int fault_at);
		t_limit[idx] = lim;
		t_fault_en[idx] = fault_en;
		t_fault_at[idx] = fault_at;
	endtask

	// Cyclic destinations 1..6, class 1 above address 3
	task automatic model_run(input int idx);
		int n;
		int cls;
		int dat;
		e_count0[idx] = 0;
		e_count1[idx] = 0;
		e_err0[idx] = 0;
		e_err1[idx] = 0;
		for (n = 0; n < t_limit[idx]; n++) begin
			if (m_dst == 6)
				m_dst = 1;
			else
				m_dst = m_dst + 1;
			cls = (m_dst > 3) ? 1 : 0;
			dat = m_cnt[cls];
			m_cnt[cls] = (m_cnt[cls] + 1) % 16;
			if (t_fault_en[idx] != 0 && n == t_fault_at[idx]) begin
				// Router flips data bit 0
				dat = dat ^ 1;
				if (cls == 0)
					e_err0[idx] = 1;
				else
					e_err1[idx] = 1;
			end
			m_disp[cls] = dat;
			if (cls == 0)
				e_count0[idx] = e_count0[idx] + 1;
			else
				e_count1[idx] = e_count1[idx] + 1;
		end
		e_disp0[idx] = m_disp[0];
		e_disp1[idx] = m_disp[1];
	endtask

	task automatic build_table();
		int i;
		int lim;
		set_row(0, 6, 0, 0);
		set_row(1, 5, 1, 1);
		set_row(2, 7, 0, 0);
		// Fault on the last class 1 message also shows in disp1
		set_row(3, 4, 1, 3);
		set_row(4, 1, 0, 0);
		set_row(5, 0, 0, 0);
		lfsr = 32'h874e_045a;
		for (i = n_fixed; i < n_rows; i++) begin
			take_byte(lim);
			set_row(i, lim, 0, 0);
		end
		m_dst = 6;
		m_cnt[0] = 0;
		m_cnt[1] = 0;
		m_disp[0] = 0;
		m_disp[1] = 0;
		max_cycles = 1000;
		for (i = 0; i < n_rows; i++) begin
			model_run(i);
			max_cycles = max_cycles + 64 * t_limit[i];
		end
	endtask

	task automatic run_row(input int idx);
		@(negedge snk0_clk);
		msg_limit = 8'(t_limit[idx]);
		start = 1'b1;
		@(negedge snk0_clk);
		start = 1'b0;
		if (t_fault_en[idx] != 0) begin
			// Pulse once the earlier messages of the run are delivered
			while (int'(count0) + int'(count1) != t_fault_at[idx])
				@(negedge snk0_clk);
			inject_fault = 1'b1;
			@(negedge snk0_clk);
			inject_fault = 1'b0;
		end
		while (!done)
			@(negedge snk0_clk);
		$display("run %0d: limit %0d, fault %0d", idx, t_limit[idx], t_fault_en[idx]);
		compare("count0", 32'(count0), 32'(e_count0[idx]));
		compare("count1", 32'(count1), 32'(e_count1[idx]));
		compare("err0", 32'(err0), 32'(e_err0[idx]));
		compare("err1", 32'(err1), 32'(e_err1[idx]));
		compare("disp0", 32'(disp0), 32'(e_disp0[idx]));
		compare("disp1", 32'(disp1), 32'(e_disp1[idx]));
		// Error flags hold until the next start
		repeat (3) @(negedge snk0_clk);
		compare("done", 32'(done), 32'd1);
		compare("err0", 32'(err0), 32'(e_err0[idx]));
		compare("err1", 32'(err1), 32'(e_err1[idx]));
	endtask

	initial begin
		int i;
		cycles = 0;
		max_cycles = 1000;
		rst_n = 1'b0;
		start = 1'b0;
		msg_limit = 8'd0;
		inject_fault = 1'b0;
		build_table();
		repeat (10) @(negedge snk0_clk);
		rst_n = 1'b1;
		@(negedge snk0_clk);
		compare("done", 32'(done), 32'd0);
		compare("err0", 32'(err0), 32'd0);
		compare("err1", 32'(err1), 32'd0);
		compare("count0", 32'(count0), 32'd0);
		compare("count1", 32'(count1), 32'd0);
		compare("disp0", 32'(disp0), 32'd0);
		compare("disp1", 32'(disp1), 32'd0);
		for (i = 0; i < n_rows; i++)
			run_row(i);
		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== hdl/msg_loop_test.sv ====
`timescale 1ns/10ps
`default_nettype none

module msg_loop_test (
	input wire snk0_clk,
	input wire rst_n,
	input wire start,
	input wire [msg_pkg::cnt_w-1:0] msg_limit,
	input wire inject_fault,
	output logic done,
	output logic err0,
	output logic err1,
	output logic [msg_pkg::cnt_w-1:0] count0,
	output logic [msg_pkg::cnt_w-1:0] count1,
	output logic [3:0] disp0,
	output logic [3:0] disp1
);

	logic enable;
	logic clear;
	logic sent;
	logic idle;
	logic deliver0;
	logic deliver1;
	logic sink_err0;
	logic sink_err1;

	// Source link
	logic s_req;
	logic s_ack;
	logic [msg_pkg::asz-1:0] s_src;
	logic [msg_pkg::asz-1:0] s_dst;
	logic [msg_pkg::dsz-1:0] s_dat;
	logic [msg_pkg::rsz-1:0] s_red;

	// Router to sink 0
	logic l0_req;
	logic l0_ack;
	logic [msg_pkg::asz-1:0] l0_src;
	logic [msg_pkg::asz-1:0] l0_dst;
	logic [msg_pkg::dsz-1:0] l0_dat;
	logic [msg_pkg::rsz-1:0] l0_red;

	// Router to sink 1
	logic l1_req;
	logic l1_ack;
	logic [msg_pkg::asz-1:0] l1_src;
	logic [msg_pkg::asz-1:0] l1_dst;
	logic [msg_pkg::dsz-1:0] l1_dat;
	logic [msg_pkg::rsz-1:0] l1_red;

	loop_ctrl u_loop_ctrl (
		.snk0_clk(snk0_clk), .rst_n(rst_n),
		.start(start), .msg_limit(msg_limit),
		.sent(sent), .idle(idle),
		.deliver0(deliver0), .deliver1(deliver1),
		.err_in0(sink_err0), .err_in1(sink_err1),
		.enable(enable), .clear(clear), .done(done),
		.count0(count0), .count1(count1),
		.err0(err0), .err1(err1)
	);

	msg_source u_msg_source (
		.snk0_clk(snk0_clk), .rst_n(rst_n),
		.enable(enable), .sent(sent), .idle(idle),
		.o_req(s_req), .o_ack(s_ack),
		.o_src(s_src), .o_dst(s_dst), .o_dat(s_dat), .o_red(s_red)
	);

	msg_router u_msg_router (
		.snk0_clk(snk0_clk), .rst_n(rst_n), .inject_fault(inject_fault),
		.i_req(s_req), .i_ack(s_ack),
		.i_src(s_src), .i_dst(s_dst), .i_dat(s_dat), .i_red(s_red),
		.o0_req(l0_req), .o0_ack(l0_ack),
		.o0_src(l0_src), .o0_dst(l0_dst), .o0_dat(l0_dat), .o0_red(l0_red),
		.o1_req(l1_req), .o1_ack(l1_ack),
		.o1_src(l1_src), .o1_dst(l1_dst), .o1_dat(l1_dat), .o1_red(l1_red)
	);

	msg_sink u_sink0 (
		.snk0_clk(snk0_clk), .rst_n(rst_n), .clear(clear),
		.i_req(l0_req), .i_ack(l0_ack),
		.i_src(l0_src), .i_dst(l0_dst), .i_dat(l0_dat), .i_red(l0_red),
		.err(sink_err0), .deliver(deliver0), .disp(disp0)
	);

	msg_sink u_sink1 (
		.snk0_clk(snk0_clk), .rst_n(rst_n), .clear(clear),
		.i_req(l1_req), .i_ack(l1_ack),
		.i_src(l1_src), .i_dst(l1_dst), .i_dat(l1_dat), .i_red(l1_red),
		.err(sink_err1), .deliver(deliver1), .disp(disp1)
	);

endmodule

`default_nettype wire

// ==== hdl/loop_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

module loop_ctrl (
	input wire snk0_clk,
	input wire rst_n,
	input wire start,
	input wire [msg_pkg::cnt_w-1:0] msg_limit,
	input wire sent,
	input wire idle,
	input wire deliver0,
	input wire deliver1,
	input wire err_in0,
	input wire err_in1,
	output logic enable,
	output logic clear,
	output logic done,
	output logic [msg_pkg::cnt_w-1:0] count0,
	output logic [msg_pkg::cnt_w-1:0] count1,
	output logic err0,
	output logic err1
);

	logic run;
	logic [msg_pkg::cnt_w-1:0] limit_r;
	logic [msg_pkg::cnt_w-1:0] sent_cnt;

	always_ff @(posedge snk0_clk or negedge rst_n) begin
		if (!rst_n) begin
			run <= 1'b0;
			enable <= 1'b0;
			clear <= 1'b0;
			done <= 1'b0;
			limit_r <= '0;
			sent_cnt <= '0;
			count0 <= '0;
			count1 <= '0;
			err0 <= 1'b0;
			err1 <= 1'b0;
		end else begin
			clear <= 1'b0;
			err0 <= err_in0;
			err1 <= err_in1;
			if (start) begin
				clear <= 1'b1;
				run <= 1'b1;
				done <= 1'b0;
				limit_r <= msg_limit;
				sent_cnt <= '0;
				count0 <= '0;
				count1 <= '0;
				// A zero limit finishes without sending
				enable <= (msg_limit != '0);
			end else begin
				if (deliver0)
					count0 <= count0 + 1'b1;
				if (deliver1)
					count1 <= count1 + 1'b1;
				if (sent) begin
					sent_cnt <= sent_cnt + 1'b1;
					if ((sent_cnt + 1'b1) == limit_r)
						enable <= 1'b0;
				end
				// Last message has drained through the loop
				if (run && !enable && idle) begin
					run <= 1'b0;
					done <= 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== hdl/msg_sink.sv ====
`timescale 1ns/10ps
`default_nettype none

module msg_sink (
	input wire snk0_clk,
	input wire rst_n,
	input wire clear,
	input wire i_req,
	output logic i_ack,
	input wire [msg_pkg::asz-1:0] i_src,
	input wire [msg_pkg::asz-1:0] i_dst,
	input wire [msg_pkg::dsz-1:0] i_dat,
	input wire [msg_pkg::rsz-1:0] i_red,
	output logic err,
	output logic deliver,
	output logic [3:0] disp
);

	logic has_msg;
	logic has_red;
	logic done_cks;
	logic take;
	logic recompute;
	logic msg_bad;
	logic seq_bad;
	logic [msg_pkg::dsz-1:0] back_dat;
	logic [msg_pkg::asz-1:0] cap_src;
	logic [msg_pkg::asz-1:0] cap_dst;
	logic [msg_pkg::dsz-1:0] cap_dat;
	logic [msg_pkg::rsz-1:0] cap_red;
	logic [msg_pkg::rsz-1:0] red_r;
	logic [msg_pkg::rsz-1:0] calc_red;

	redun_calc u_redun_calc (
		.src(cap_src),
		.dst(cap_dst),
		.dat(cap_dat),
		.red(calc_red)
	);

	assign take = i_req && !i_ack && !has_msg;
	assign recompute = i_req && !i_ack && has_msg && !has_red;

	// Wrong source or wrong redundancy
	assign msg_bad = (cap_src != msg_pkg::dbg_src) || (cap_red != red_r);
	// Data must follow the previous one unless the previous was 15 or above
	assign seq_bad = (back_dat <= 8'd14) && ((back_dat + 1'b1) != cap_dat);

	always_ff @(posedge snk0_clk) begin
		if (take) begin
			cap_src <= i_src;
			cap_dst <= i_dst;
			cap_dat <= i_dat;
			cap_red <= i_red;
		end
		if (recompute)
			red_r <= calc_red;
	end

	always_ff @(posedge snk0_clk or negedge rst_n) begin
		if (!rst_n) begin
			has_msg <= 1'b0;
			has_red <= 1'b0;
			done_cks <= 1'b0;
			i_ack <= 1'b0;
			err <= 1'b0;
			deliver <= 1'b0;
			disp <= '0;
			back_dat <= 8'd15;
		end else begin
			deliver <= 1'b0;
			if (clear)
				err <= 1'b0;
			if (i_req && !i_ack) begin
				if (!has_msg) begin
					has_msg <= 1'b1;
				end else if (!has_red) begin
					has_red <= 1'b1;
				end else if (!done_cks) begin
					done_cks <= 1'b1;
					if (msg_bad) begin
						err <= 1'b1;
						// Corrupt data cannot anchor the sequence, resync on the next one
						back_dat <= 8'd15;
					end else begin
						if (seq_bad)
							err <= 1'b1;
						back_dat <= cap_dat;
					end
				end else begin
					has_msg <= 1'b0;
					has_red <= 1'b0;
					done_cks <= 1'b0;
					i_ack <= 1'b1;
					deliver <= 1'b1;
					disp <= cap_dat[3:0];
				end
			end else if (!i_req && i_ack) begin
				i_ack <= 1'b0;
			end
		end
	end

	a_ack_after_req: assert property (@(posedge snk0_clk) disable iff (!rst_n)
		$rose(i_ack) |-> i_req);

endmodule

`default_nettype wire

// ==== hdl/msg_router.sv ====
`timescale 1ns/10ps
`default_nettype none

module msg_router (
	input wire snk0_clk,
	input wire rst_n,
	input wire inject_fault,
	input wire i_req,
	output logic i_ack,
	input wire [msg_pkg::asz-1:0] i_src,
	input wire [msg_pkg::asz-1:0] i_dst,
	input wire [msg_pkg::dsz-1:0] i_dat,
	input wire [msg_pkg::rsz-1:0] i_red,
	output logic o0_req,
	input wire o0_ack,
	output logic [msg_pkg::asz-1:0] o0_src,
	output logic [msg_pkg::asz-1:0] o0_dst,
	output logic [msg_pkg::dsz-1:0] o0_dat,
	output logic [msg_pkg::rsz-1:0] o0_red,
	output logic o1_req,
	input wire o1_ack,
	output logic [msg_pkg::asz-1:0] o1_src,
	output logic [msg_pkg::asz-1:0] o1_dst,
	output logic [msg_pkg::dsz-1:0] o1_dat,
	output logic [msg_pkg::rsz-1:0] o1_red
);

	typedef enum logic [1:0] {
		st_idle,
		st_fwd,
		st_wait,
		st_done
	} rt_state_t;

	rt_state_t state;
	logic sel;
	logic fault_armed;
	logic latch;
	logic sel_ack;
	logic [msg_pkg::asz-1:0] m_src;
	logic [msg_pkg::asz-1:0] m_dst;
	logic [msg_pkg::dsz-1:0] m_dat;
	logic [msg_pkg::rsz-1:0] m_red;

	assign latch = (state == st_idle) && i_req;
	assign sel_ack = sel ? o1_ack : o0_ack;

	always_ff @(posedge snk0_clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= st_idle;
			sel <= 1'b0;
			fault_armed <= 1'b0;
			i_ack <= 1'b0;
			o0_req <= 1'b0;
			o1_req <= 1'b0;
		end else begin
			// Armed fault is spent on the next latched message
			fault_armed <= (fault_armed && !latch) || inject_fault;
			case (state)
				st_idle: begin
					if (i_req) begin
						sel <= msg_pkg::is_upper(i_dst);
						state <= st_fwd;
					end
				end
				st_fwd: begin
					o0_req <= !sel;
					o1_req <= sel;
					state <= st_wait;
				end
				st_wait: begin
					if (sel_ack) begin
						o0_req <= 1'b0;
						o1_req <= 1'b0;
						i_ack <= 1'b1;
						state <= st_done;
					end
				end
				default: begin
					// Both links must be quiet before the next message
					if (!i_req && !sel_ack) begin
						i_ack <= 1'b0;
						state <= st_idle;
					end
				end
			endcase
		end
	end

	always_ff @(posedge snk0_clk) begin
		if (latch) begin
			m_src <= i_src;
			m_dst <= i_dst;
			m_dat <= {i_dat[msg_pkg::dsz-1:1], i_dat[0] ^ fault_armed};
			m_red <= i_red;
		end
	end

	assign o0_src = m_src;
	assign o0_dst = m_dst;
	assign o0_dat = m_dat;
	assign o0_red = m_red;
	assign o1_src = m_src;
	assign o1_dst = m_dst;
	assign o1_dat = m_dat;
	assign o1_red = m_red;

	// Source fields must hold while its request is pending
	a_in_stable: assert property (@(posedge snk0_clk) disable iff (!rst_n)
		i_req && $past(i_req) |-> $stable({i_src, i_dst, i_dat, i_red}));

endmodule

`default_nettype wire

// ==== hdl/msg_source.sv ====
`timescale 1ns/10ps
`default_nettype none

module msg_source (
	input wire snk0_clk,
	input wire rst_n,
	input wire enable,
	output logic sent,
	output logic idle,
	output logic o_req,
	input wire o_ack,
	output logic [msg_pkg::asz-1:0] o_src,
	output logic [msg_pkg::asz-1:0] o_dst,
	output logic [msg_pkg::dsz-1:0] o_dat,
	output logic [msg_pkg::rsz-1:0] o_red
);

	logic has_dst;
	logic has_dat;
	logic has_red;
	logic req_r;
	logic [msg_pkg::asz-1:0] dst_r;
	logic [msg_pkg::dsz-1:0] dat_r;
	logic [msg_pkg::rsz-1:0] red_r;
	logic [3:0] cnt0;
	logic [3:0] cnt1;
	logic [msg_pkg::rsz-1:0] calc_red;

	redun_calc u_redun_calc (
		.src(msg_pkg::dbg_src),
		.dst(dst_r),
		.dat(dat_r),
		.red(calc_red)
	);

	always_ff @(posedge snk0_clk or negedge rst_n) begin
		if (!rst_n) begin
			has_dst <= 1'b0;
			has_dat <= 1'b0;
			has_red <= 1'b0;
			req_r <= 1'b0;
			sent <= 1'b0;
			// First message goes to min_addr
			dst_r <= msg_pkg::max_addr;
			dat_r <= '0;
			red_r <= '0;
			cnt0 <= '0;
			cnt1 <= '0;
		end else begin
			sent <= 1'b0;
			if (!req_r && !o_ack) begin
				if (!has_dst) begin
					// A new message only starts while enabled
					if (enable) begin
						has_dst <= 1'b1;
						if (dst_r == msg_pkg::max_addr)
							dst_r <= msg_pkg::min_addr;
						else
							dst_r <= dst_r + 1'b1;
					end
				end else if (!has_dat) begin
					has_dat <= 1'b1;
					if (msg_pkg::is_upper(dst_r)) begin
						dat_r <= {4'h0, cnt1};
						cnt1 <= cnt1 + 1'b1;
					end else begin
						dat_r <= {4'h0, cnt0};
						cnt0 <= cnt0 + 1'b1;
					end
				end else if (!has_red) begin
					has_red <= 1'b1;
					red_r <= calc_red;
				end else begin
					req_r <= 1'b1;
				end
			end
			// Ack closes the handshake and frees the source
			if (req_r && o_ack) begin
				has_dst <= 1'b0;
				has_dat <= 1'b0;
				has_red <= 1'b0;
				req_r <= 1'b0;
				sent <= 1'b1;
			end
		end
	end

	// Nothing in flight on the link
	assign idle = !req_r && !has_dst && !o_ack;

	assign o_req = req_r;
	assign o_src = msg_pkg::dbg_src;
	assign o_dst = dst_r;
	assign o_dat = dat_r;
	assign o_red = red_r;

	a_ack_after_req: assert property (@(posedge snk0_clk) disable iff (!rst_n)
		$rose(o_ack) |-> o_req);

endmodule

`default_nettype wire

// ==== hdl/redun_calc.sv ====
`timescale 1ns/10ps
`default_nettype none

module redun_calc (
	input wire [msg_pkg::asz-1:0] src,
	input wire [msg_pkg::asz-1:0] dst,
	input wire [msg_pkg::dsz-1:0] dat,
	output logic [msg_pkg::rsz-1:0] red
);

	// Fold both address fields and both data nibbles into one nibble
	always_comb begin
		red = src ^ dst;
		red = red ^ dat[msg_pkg::rsz-1:0];
		red = red ^ dat[msg_pkg::dsz-1:msg_pkg::rsz];
	end

endmodule

`default_nettype wire

// ==== hdl/msg_pkg.sv ====
`default_nettype none

package msg_pkg;

	// Message field widths
	localparam int unsigned asz = 4;
	localparam int unsigned dsz = 8;
	localparam int unsigned rsz = 4;

	// Destinations visited by the source, in order, wrapping
	localparam logic [asz-1:0] min_addr = 4'd1;
	localparam logic [asz-1:0] max_addr = 4'd6;

	// Map boundary between the two sinks
	localparam logic [asz-1:0] ref_val = 4'd3;

	// Source address carried by every message
	localparam logic [asz-1:0] dbg_src = 4'hA;

	// Message limit and delivery counters
	localparam int unsigned cnt_w = 8;

	// Address map: destinations above ref_val go to sink 1
	function automatic logic is_upper(input logic [asz-1:0] dst);
		return dst > ref_val;
	endfunction

endpackage

`default_nettype wire
